// ==== bench/spram_subsys_sva.sv ====
/* Handshake checks on the scratchpad top level, bound into spram_subsys.
   Each failure raises $error and adds one to err_cnt. */
`default_nettype none

module spram_subsys_sva (
	input wire                       clk,
	input wire                       arst_n,
	input wire                       req_valid,
	input wire                       req_ready,
	input wire mem_bus_pkg::addr_t   req_addr,
	input wire mem_bus_pkg::data_t   req_wdata,
	input wire mem_bus_pkg::strb_t   req_wstrb,
	input wire                       rsp_valid,
	input wire                       rsp_ready,
	input wire mem_bus_pkg::data_t   rsp_rdata,
	input wire mem_bus_pkg::kind_t   rsp_kind
);

	int err_cnt = 0;

	// Stalled response keeps its fields
	// rdata only matters for reads
	rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_kind)
			&& (rsp_kind == mem_bus_pkg::KIND_WRITE || $stable(rsp_rdata)))
	else begin
		err_cnt++;
		$error("response changed while stalled");
	end

	// Master side of the request channel
	req_hold: assume property (@(posedge clk) disable iff (!arst_n)
		req_valid && !req_ready |=> req_valid && $stable(req_addr)
			&& $stable(req_wdata) && $stable(req_wstrb))
	else begin
		err_cnt++;
		$error("request changed while stalled");
	end

	// Quiet while in reset
	rsp_reset: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
	else begin
		err_cnt++;
		$error("rsp_valid high during reset");
	end

endmodule

`default_nettype wire

// ==== bench/spram_subsys_tb.sv ====
/* Directed testbench for the scratchpad subsystem with a byte-lane reference model.
   Compile with tb.f and run spram_subsys_tb as the top module. */
`default_nettype none

`include "spram_params.svh"

module spram_subsys_tb;

	localparam int DRV = 1;
	localparam int POOL = 16;
	localparam int unsigned RNG_SEED = 32'hfe7b_4255;
	// Tests take about 350 cycles in all
	// Limit leaves more than ten times that
	localparam int TIMEOUT_CYCLES = 4000;
	// Word indices on both sides of the bank boundary
	localparam int FULL_IDX [8] = '{0, 1, 5, `SPRAM_MACRO_DEPTH - 1, `SPRAM_MACRO_DEPTH,
		`SPRAM_MACRO_DEPTH + 5, 2 * `SPRAM_MACRO_DEPTH - 1, 2};

	logic clk;
	logic arst_n;
	logic req_valid;
	logic req_ready;
	mem_bus_pkg::addr_t req_addr;
	mem_bus_pkg::data_t req_wdata;
	mem_bus_pkg::strb_t req_wstrb;
	logic rsp_valid;
	logic rsp_ready;
	mem_bus_pkg::data_t rsp_rdata;
	mem_bus_pkg::kind_t rsp_kind;

	// Reference memory, one entry per byte lane
	logic [7:0] ref_mem [int];
	// Expected responses in request order
	mem_bus_pkg::kind_t exp_kind [$];
	mem_bus_pkg::data_t exp_data [$];
	bit exp_known [$];
	mem_bus_pkg::addr_t pool [POOL];

	int mismatch_cnt = 0;
	int fail_cnt = 0;
	int cycle_cnt = 0;

	spram_subsys spram_subsys_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_rdata (rsp_rdata),
		.rsp_kind  (rsp_kind)
	);

	bind spram_subsys spram_subsys_sva sva_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_rdata (rsp_rdata),
		.rsp_kind  (rsp_kind)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog
	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, responses stopped arriving", cycle_cnt);
		$display("Simulation failed");
		$finish;
	end

	// Model update and expectation at the request handshake
	task automatic record_req(input mem_bus_pkg::addr_t a, input mem_bus_pkg::data_t d,
			input mem_bus_pkg::strb_t s);
		int base;
		mem_bus_pkg::data_t w;
		bit known;
		bit wrote;
		base = int'(a >> 2) * 4;
		w = '0;
		known = 1'b1;
		wrote = 1'b0;
		for (int b = 0; b < 4; b++) begin
			if (s[b]) begin
				ref_mem[base + b] = d[b*8 +: 8];
				wrote = 1'b1;
			end else if (ref_mem.exists(base + b)) begin
				w[b*8 +: 8] = ref_mem[base + b];
			end else begin
				known = 1'b0;
			end
		end
		// A request that stores no byte is a read
		exp_kind.push_back(wrote ? mem_bus_pkg::KIND_WRITE : mem_bus_pkg::KIND_READ);
		exp_data.push_back(w);
		exp_known.push_back(known);
	endtask

	// Called at drive time, returns at drive time after the handshake
	task automatic send_req(input mem_bus_pkg::addr_t a, input mem_bus_pkg::data_t d,
			input mem_bus_pkg::strb_t s);
		req_valid = 1'b1;
		req_addr = a;
		req_wdata = d;
		req_wstrb = s;
		@(posedge clk);
		while (!req_ready) begin
			@(posedge clk);
		end
		record_req(a, d, s);
		#DRV;
		req_valid = 1'b0;
	endtask

	// Waits for every outstanding response, returns at drive time
	task automatic drain();
		while (exp_kind.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
		#DRV;
	endtask

	task automatic check_response();
		mem_bus_pkg::kind_t k;
		mem_bus_pkg::data_t d;
		bit known;
		assert (exp_kind.size() != 0) else begin
			fail_cnt++;
			$display("Response arrived with no request outstanding");
		end
		if (exp_kind.size() != 0) begin
			k = exp_kind.pop_front();
			d = exp_data.pop_front();
			known = exp_known.pop_front();
			assert (rsp_kind == k) else begin
				mismatch_cnt++;
				$display("Mismatch rsp_kind: got %h, expected %h", rsp_kind, k);
			end
			// Write responses carry no data
			if (k == mem_bus_pkg::KIND_READ && known) begin
				assert (rsp_rdata == d) else begin
					mismatch_cnt++;
					$display("Mismatch rsp_rdata: got %h, expected %h", rsp_rdata, d);
				end
			end
		end
	endtask

	always @(posedge clk) begin
		if (arst_n && rsp_valid && rsp_ready) begin
			check_response();
		end
	end

	// Idle after reset, then first response latency
	task automatic run_after_reset();
		int lat;
		rsp_ready = 1'b1;
		repeat (6) begin
			@(negedge clk);
			assert (!rsp_valid) else begin
				fail_cnt++;
				$display("rsp_valid went high before any request was accepted");
			end
		end
		@(posedge clk);
		#DRV;
		send_req(17'h0_0100, 32'hdead_beef, 4'hf);
		lat = 0;
		@(negedge clk);
		while (!rsp_valid && lat < 16) begin
			lat++;
			@(negedge clk);
		end
		assert (lat == 2) else begin
			mismatch_cnt++;
			$display("Mismatch rsp_valid latency: got %h, expected %h", lat, 2);
		end
		drain();
	endtask

	// Tagged data per word exposes bank aliasing
	task automatic run_full_words();
		for (int n = 0; n < 8; n++) begin
			send_req(mem_bus_pkg::addr_t'(FULL_IDX[n] * 4), 32'h5a00_0000 | FULL_IDX[n], 4'hf);
		end
		for (int n = 0; n < 8; n++) begin
			send_req(mem_bus_pkg::addr_t'(FULL_IDX[n] * 4), '0, '0);
		end
		drain();
	endtask

	// Known word restored before each strobe pattern
	task automatic run_partial();
		for (int s = 1; s < 16; s++) begin
			send_req(17'h0_0a40, 32'h0123_4567, 4'hf);
			send_req(17'h0_0a40, 32'hc3d2_e1f0 ^ {8{4'(s)}}, 4'(s));
			send_req(17'h0_0a40, '0, '0);
		end
		drain();
	endtask

	// Pool words filled first, then mixed traffic at one per cycle
	task automatic run_back_to_back();
		for (int n = 0; n < POOL; n++) begin
			pool[n] = mem_bus_pkg::addr_t'($urandom) & ~17'h3;
			send_req(pool[n], $urandom, 4'hf);
		end
		for (int n = 0; n < 32; n++) begin
			send_req(pool[$urandom_range(POOL - 1, 0)], $urandom,
				mem_bus_pkg::strb_t'($urandom_range(15, 0)));
		end
		drain();
	endtask

	// Same traffic with rsp_ready toggled at random
	task automatic run_backpressure();
		bit done;
		done = 1'b0;
		fork
			begin
				for (int n = 0; n < 48; n++) begin
					send_req(pool[$urandom_range(POOL - 1, 0)], $urandom,
						mem_bus_pkg::strb_t'($urandom_range(15, 0)));
				end
				drain();
				done = 1'b1;
			end
			while (!done) begin
				@(posedge clk);
				#DRV;
				rsp_ready = 1'($urandom_range(1, 0));
			end
		join
		rsp_ready = 1'b1;
	endtask

	initial begin
		void'($urandom(RNG_SEED));
		arst_n = 1'b0;
		req_valid = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_wstrb = '0;
		rsp_ready = 1'b0;
		repeat (10) @(posedge clk);
		#DRV;
		arst_n = 1'b1;
		run_after_reset();
		run_full_words();
		run_partial();
		run_back_to_back();
		run_backpressure();
		repeat (4) @(posedge clk);
		$display("Summary: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_cnt, fail_cnt, spram_subsys_inst.sva_inst.err_cnt);
		if (mismatch_cnt + fail_cnt + spram_subsys_inst.sva_inst.err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/mem_bus_pkg.sv ====
/* Types of the bus side of the scratchpad: request fields and response kind.
   Used by the slices and the top level through scoped names. */
`default_nettype none

`include "spram_params.svh"

package mem_bus_pkg;

	// Byte address, low two bits ignored
	typedef logic [`SPRAM_ADDR_W-1:0] addr_t;

	// Bus data word
	typedef logic [`SPRAM_DATA_W-1:0] data_t;

	// One strobe per byte lane
	// All zero marks a read
	typedef logic [`SPRAM_DATA_W/8-1:0] strb_t;

	// Kind of access, carried with every in-flight request
	typedef enum logic {
		KIND_READ  = 1'b0,
		KIND_WRITE = 1'b1
	} kind_t;

endpackage

`default_nettype wire

// ==== hw/mem_req_slice.sv ====
/* Input register slice of the scratchpad: holds one request and issues it
   to the bank when the response side grants credit. */
`default_nettype none

module mem_req_slice (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       req_valid,
	output logic                      req_ready,
	input  wire mem_bus_pkg::addr_t   req_addr,
	input  wire mem_bus_pkg::data_t   req_wdata,
	input  wire mem_bus_pkg::strb_t   req_wstrb,
	input  wire                       credit,
	output logic                      acc_en,
	output mem_bus_pkg::addr_t        acc_addr,
	output mem_bus_pkg::data_t        acc_wdata,
	output mem_bus_pkg::strb_t        acc_wstrb,
	output mem_bus_pkg::kind_t        acc_kind
);

	// Set one cycle after reset release, keeps ready low until then
	logic run_q;

	// Entry holds a request
	logic full_q;

	// Request payload
	mem_bus_pkg::addr_t addr_q;
	mem_bus_pkg::data_t wdata_q;
	mem_bus_pkg::strb_t wstrb_q;

	logic issue;
	logic accept;

	// Entry leaves on the first cycle with credit
	assign issue = full_q && credit;

	// Refill in the same cycle as the issue
	assign req_ready = run_q && (!full_q || issue);
	assign accept = req_valid && req_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run_q <= 1'b0;
			full_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (accept) begin
				full_q <= 1'b1;
			end else if (issue) begin
				full_q <= 1'b0;
			end
		end
	end

	// Payload loads on the handshake only
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			wstrb_q <= req_wstrb;
		end
	end

	// Bank access port
	assign acc_en = issue;
	assign acc_addr = addr_q;
	assign acc_wdata = wdata_q;
	assign acc_wstrb = wstrb_q;

	// Any strobe set makes it a write
	assign acc_kind = (wstrb_q != '0) ? mem_bus_pkg::KIND_WRITE : mem_bus_pkg::KIND_READ;

endmodule

`default_nettype wire

// ==== hw/mem_resp_slice.sv ====
/* Output side of the scratchpad: marks the access in flight and queues
   results in a two-entry response FIFO, returning credit to the input side. */
`default_nettype none

module mem_resp_slice (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       acc_en,
	input  wire mem_bus_pkg::kind_t   acc_kind,
	input  wire mem_bus_pkg::data_t   bank_rdata,
	output logic                      credit,
	output logic                      rsp_valid,
	input  wire                       rsp_ready,
	output mem_bus_pkg::data_t        rsp_rdata,
	output mem_bus_pkg::kind_t        rsp_kind
);

	localparam int DEPTH = 2;

	// Access whose bank data arrives this cycle
	logic pend_q;
	mem_bus_pkg::kind_t pend_kind_q;

	// FIFO storage and pointers
	mem_bus_pkg::data_t data_q [DEPTH];
	mem_bus_pkg::kind_t kind_q [DEPTH];
	logic wr_ptr_q;
	logic rd_ptr_q;
	logic [1:0] count_q;

	logic push;
	logic pop;
	logic [1:0] occ;
	logic [1:0] total;

	assign push = pend_q;
	assign pop = rsp_valid && rsp_ready;

	// Entries left after this cycle's pop
	// counting the pop keeps one request per cycle with rsp_ready high
	assign occ = count_q - {1'b0, pop};
	assign total = occ + {1'b0, pend_q};
	assign credit = total < 2'(DEPTH);

	// Bank data is valid one cycle after acc_en
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_q <= 1'b0;
		end else begin
			pend_q <= acc_en;
		end
	end

	always_ff @(posedge clk) begin
		if (acc_en) begin
			pend_kind_q <= acc_kind;
		end
	end

	// FIFO control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr_q <= 1'b0;
			rd_ptr_q <= 1'b0;
			count_q <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr_q <= !wr_ptr_q;
			end
			if (pop) begin
				rd_ptr_q <= !rd_ptr_q;
			end
			count_q <= count_q + {1'b0, push} - {1'b0, pop};
		end
	end

	// Write data is stored too, the kind tells it apart
	always_ff @(posedge clk) begin
		if (push) begin
			data_q[wr_ptr_q] <= bank_rdata;
			kind_q[wr_ptr_q] <= pend_kind_q;
		end
	end

	// Head of the FIFO, stable until popped
	assign rsp_valid = count_q != 2'd0;
	assign rsp_rdata = data_q[rd_ptr_q];
	assign rsp_kind = kind_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hw/spram_bank.sv ====
/* 32-bit 128 kB scratchpad bank built from four SRAM macros.
   Splits an access into bank select, lane halves and nibble masks. */
`default_nettype none

`include "spram_params.svh"

module spram_bank (
	input  wire                       clk,
	input  wire                       acc_en,
	input  wire mem_bus_pkg::addr_t   acc_addr,
	input  wire mem_bus_pkg::data_t   acc_wdata,
	input  wire mem_bus_pkg::strb_t   acc_wstrb,
	output mem_bus_pkg::data_t        bank_rdata
);

	// Half-word lanes per bus word
	localparam int LANES = `SPRAM_DATA_W / `SPRAM_MACRO_W;
	localparam int STRB_PER_LANE = `SPRAM_MACRO_W / 8;
	localparam int NIBS = $bits(spram_geom_pkg::nib_mask_t);

	spram_geom_pkg::bank_sel_t acc_bank;
	spram_geom_pkg::word_idx_t acc_word;
	logic acc_we;

	// Read data of every macro
	spram_geom_pkg::half_t blk_rdata [`SPRAM_MACRO_CNT];

	// Bank of the last read, steers the output mux
	spram_geom_pkg::bank_sel_t rd_bank_q;

	// Address split
	assign acc_bank = acc_addr[spram_geom_pkg::BANK_BIT];
	assign acc_word = acc_addr[spram_geom_pkg::WORD_LSB +: spram_geom_pkg::WORD_IDX_W];
	assign acc_we = |acc_wstrb;

	// Macro g sits in bank g / LANES, lane g % LANES
	for (genvar g = 0; g < `SPRAM_MACRO_CNT; g++) begin : g_macro
		localparam int BANK = g / LANES;
		localparam int LANE = g % LANES;

		logic cs;
		spram_geom_pkg::nib_mask_t wmask;

		assign cs = acc_en && (acc_bank == spram_geom_pkg::bank_sel_t'(BANK));

		// Each byte strobe enables both of its nibbles
		always_comb begin
			for (int n = 0; n < NIBS; n++) begin
				wmask[n] = acc_wstrb[LANE * STRB_PER_LANE + n / 2];
			end
		end

		spram_block ram_inst (
			.clk   (clk),
			.cs    (cs),
			.addr  (acc_word),
			.wdata (acc_wdata[LANE * `SPRAM_MACRO_W +: `SPRAM_MACRO_W]),
			.wmask (wmask),
			.we    (acc_we),
			.rdata (blk_rdata[g])
		);
	end

	// Follows the access so the mux matches the macro output register
	always_ff @(posedge clk) begin
		if (acc_en) begin
			rd_bank_q <= acc_bank;
		end
	end

	// Output mux, one cycle behind the access
	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			bank_rdata[l * `SPRAM_MACRO_W +: `SPRAM_MACRO_W] = blk_rdata[rd_bank_q * LANES + l];
		end
	end

endmodule

`default_nettype wire

// ==== hw/spram_block.sv ====
/* Behavioural model of one 16K x 16 single-port SRAM macro.
   Registered read, nibble-masked write, low-power pins tied awake. */
`default_nettype none

`include "spram_params.svh"

module spram_block (
	input  wire                               clk,
	input  wire                               cs,
	input  wire spram_geom_pkg::word_idx_t    addr,
	input  wire spram_geom_pkg::half_t        wdata,
	input  wire spram_geom_pkg::nib_mask_t    wmask,
	input  wire                               we,
	output spram_geom_pkg::half_t             rdata
);

	localparam int NIBS = $bits(spram_geom_pkg::nib_mask_t);

	// Storage array, contents undefined after power-up
	spram_geom_pkg::half_t mem [`SPRAM_MACRO_DEPTH];

	// Write side
	// only nibbles with their mask bit set change
	always_ff @(posedge clk) begin
		if (cs && we) begin
			for (int n = 0; n < NIBS; n++) begin
				if (wmask[n]) begin
					mem[addr][n*4 +: 4] <= wdata[n*4 +: 4];
				end
			end
		end
	end

	// Read side
	// Output register loads only on a selected read
	// Holds its value while deselected or writing, like the macro
	always_ff @(posedge clk) begin
		if (cs && !we) begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/spram_geom_pkg.sv ====
/* Types and address split of the macro array behind the bus.
   Used by the bank and the SRAM block model. */
`default_nettype none

`include "spram_params.svh"

package spram_geom_pkg;

	// Word address starts above the byte offset
	localparam int WORD_LSB = $clog2(`SPRAM_DATA_W / 8);
	localparam int WORD_IDX_W = $clog2(`SPRAM_MACRO_DEPTH);

	// Top byte address bit, i.e. word address bit 14
	localparam int BANK_BIT = `SPRAM_ADDR_W - 1;

	// Word index inside one macro
	typedef logic [WORD_IDX_W-1:0] word_idx_t;

	// Macro data
	typedef logic [`SPRAM_MACRO_W-1:0] half_t;

	// One write enable per nibble
	typedef logic [`SPRAM_MACRO_W/4-1:0] nib_mask_t;

	// Which pair of macros holds the word
	typedef logic bank_sel_t;

endpackage

`default_nettype wire

// ==== hw/spram_params.svh ====
/* Sizing macros for the scratchpad memory subsystem.
   Included by the packages and by modules that size their storage. */
`ifndef SPRAM_PARAMS_SVH
`define SPRAM_PARAMS_SVH

// Byte address into the 128 kB space
`define SPRAM_ADDR_W 17

// Bus word, four byte lanes
`define SPRAM_DATA_W 32

// Words in one SRAM macro
`define SPRAM_MACRO_DEPTH 16384

// Data width of one SRAM macro
`define SPRAM_MACRO_W 16

// Two banks of two half-word macros
`define SPRAM_MACRO_CNT 4

`endif

// ==== hw/spram_subsys.sv ====
/* Top level of the 128 kB scratchpad subsystem.
   Request slice feeds the bank, results return through the response slice. */
`default_nettype none

module spram_subsys (
	input  wire                       clk,
	input  wire                       arst_n,

	// Request channel
	input  wire                       req_valid,
	output logic                      req_ready,
	input  wire mem_bus_pkg::addr_t   req_addr,
	input  wire mem_bus_pkg::data_t   req_wdata,
	input  wire mem_bus_pkg::strb_t   req_wstrb,

	// Response channel
	output logic                      rsp_valid,
	input  wire                       rsp_ready,
	output mem_bus_pkg::data_t        rsp_rdata,
	output mem_bus_pkg::kind_t        rsp_kind
);

	// Bank access port
	logic acc_en;
	mem_bus_pkg::addr_t acc_addr;
	mem_bus_pkg::data_t acc_wdata;
	mem_bus_pkg::strb_t acc_wstrb;

	// Kind of the issued access, to the response side
	mem_bus_pkg::kind_t acc_kind;

	// Read data, one cycle after acc_en
	mem_bus_pkg::data_t bank_rdata;

	// Room for one more access
	logic credit;

	// Input register slice
	mem_req_slice req_slice_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.credit    (credit),
		.acc_en    (acc_en),
		.acc_addr  (acc_addr),
		.acc_wdata (acc_wdata),
		.acc_wstrb (acc_wstrb),
		.acc_kind  (acc_kind)
	);

	// Four macros, two banks
	spram_bank bank_inst (
		.clk        (clk),
		.acc_en     (acc_en),
		.acc_addr   (acc_addr),
		.acc_wdata  (acc_wdata),
		.acc_wstrb  (acc_wstrb),
		.bank_rdata (bank_rdata)
	);

	// In-flight tracking and response FIFO
	mem_resp_slice resp_slice_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.acc_en     (acc_en),
		.acc_kind   (acc_kind),
		.bank_rdata (bank_rdata),
		.credit     (credit),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp_rdata  (rsp_rdata),
		.rsp_kind   (rsp_kind)
	);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/mem_bus_pkg.sv
hw/spram_geom_pkg.sv
hw/spram_block.sv
hw/spram_bank.sv
hw/mem_req_slice.sv
hw/mem_resp_slice.sv
hw/spram_subsys.sv
bench/spram_subsys_sva.sv
bench/spram_subsys_tb.sv
